/* verilog/sata_phy_pkg.sv */
`default_nettype none

package sata_phy_pkg;

   typedef logic [31:0] dword_t;
   typedef logic [3:0]  kflag_t;
   typedef logic [7:0]  prim_code_t;
   typedef logic [2:0]  rxstatus_t;

   // Primitive codes reported by the decoder
   localparam prim_code_t PRIM_NONE    = 8'h00;
   localparam prim_code_t PRIM_ALIGN   = 8'h01;
   localparam prim_code_t PRIM_SYNC    = 8'h02;
   localparam prim_code_t PRIM_D10_2   = 8'h03;
   localparam prim_code_t PRIM_CONT    = 8'h04;
   localparam prim_code_t PRIM_OTHER_K = 8'hff;

   // Primitive dwords, the K character sits in the low byte
   localparam dword_t ALIGN_DWORD = 32'h7B4A_4ABC;
   localparam dword_t SYNC_DWORD  = 32'hB5B5_957C;
   localparam dword_t CONT_DWORD  = 32'h9999_AA7C;
   localparam dword_t D10_2_DWORD = 32'h4A4A_4A4A;
   localparam kflag_t ALIGN_K     = 4'b0001;
   localparam kflag_t SYNC_K      = 4'b0001;

   // GTP RXSTATUS codes during OOB signalling
   localparam rxstatus_t RXSTATUS_COMINIT = 3'b100;
   localparam rxstatus_t RXSTATUS_COMWAKE = 3'b010;

   // TX phase alignment windows
   localparam int PHASE_ALIGN_CYCLES = 32;
   localparam int SET_PHASE_CYCLES   = 64;
   localparam int SYNC_CNT_W         = $clog2(SET_PHASE_CYCLES);

   // OOB timing in TXUSRCLK2 cycles
   localparam int COMINIT_TIMEOUT = 2048;
   localparam int ALIGN_TIMEOUT   = 4096;
   localparam int OOB_TIMER_W     = $clog2(ALIGN_TIMEOUT);
   localparam int NONALIGN_NEEDED = 3;

   // Two ALIGN dwords follow every ALIGN_INTERVAL dwords
   localparam int ALIGN_INTERVAL = 256;
   localparam int ALIGN_CNT_W    = $clog2(ALIGN_INTERVAL + 2);

   // Pointers carry one extra wrap bit
   localparam int FIFO_DEPTH = 4;
   localparam int CREDIT_W   = $clog2(FIFO_DEPTH) + 1;

   typedef enum logic [1:0] {
      MODE_IDLE,
      MODE_D10_2,
      MODE_ALIGN,
      MODE_DATA
   } tx_mode_t;

   typedef enum logic [2:0] {
      OOB_IDLE,
      OOB_COMRESET,
      OOB_WAIT_COMINIT,
      OOB_COMWAKE,
      OOB_WAIT_COMWAKE,
      OOB_WAIT_ALIGN,
      OOB_SEND_ALIGN,
      OOB_LINK_UP
   } oob_state_t;

endpackage

`default_nettype wire

/* verilog/tx_word_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface tx_word_if;
   import sata_phy_pkg::*;

   dword_t data;
   kflag_t kflags;
   logic   valid;
   // Only high together with valid
   logic   pop;

   modport fifo_mp (output data, output kflags, output valid, input pop);
   modport mux_mp (input data, input kflags, input valid, output pop);

endinterface

`default_nettype wire

/* verilog/prim_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module prim_decoder
(
   input  sata_phy_pkg::dword_t     data_i,
   input  sata_phy_pkg::kflag_t     kflags_i,
   output sata_phy_pkg::prim_code_t code_o
);
   import sata_phy_pkg::*;

   always_comb
   begin
      code_o = PRIM_NONE;
      if (kflags_i == ALIGN_K && data_i == ALIGN_DWORD)
      begin
         code_o = PRIM_ALIGN;
      end
      else if (kflags_i == SYNC_K && data_i == SYNC_DWORD)
      begin
         code_o = PRIM_SYNC;
      end
      else if (kflags_i == SYNC_K && data_i == CONT_DWORD)
      begin
         code_o = PRIM_CONT;
      end
      else if (kflags_i[0])
      begin
         // K-led but not in the table
         code_o = PRIM_OTHER_K;
      end
      else if (kflags_i == '0 && data_i == D10_2_DWORD)
      begin
         code_o = PRIM_D10_2;
      end
   end

endmodule

`default_nettype wire

/* verilog/tx_phase_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_phase_sync
(
   input  logic tile0_txusrclk20_i,
   input  logic tile0_resetdone0_i,
   output logic txenpmaphasealign_o,
   output logic txpmasetphase_o,
   output logic sync_done_o
);
   import sata_phy_pkg::*;

   logic [1:0]            rst_sync_r;
   logic [SYNC_CNT_W-1:0] cnt_r;
   logic                  en_r;
   logic                  set_r;
   logic                  done_r;

   always_ff @(posedge tile0_txusrclk20_i or negedge tile0_resetdone0_i)
   begin
      if (!tile0_resetdone0_i)
      begin
         rst_sync_r <= 2'b00;
         cnt_r      <= '0;
         en_r       <= 1'b0;
         set_r      <= 1'b0;
         done_r     <= 1'b0;
      end
      else
      begin
         rst_sync_r <= {rst_sync_r[0], 1'b1};
         cnt_r      <= cnt_r + 1'b1;
         if (rst_sync_r[1] && !done_r)
         begin
            if (!en_r)
            begin
               // Open the PMA phase-align window
               en_r  <= 1'b1;
               cnt_r <= '0;
            end
            else if (!set_r && cnt_r == SYNC_CNT_W'(PHASE_ALIGN_CYCLES - 1))
            begin
               set_r <= 1'b1;
               cnt_r <= '0;
            end
            else if (set_r && cnt_r == SYNC_CNT_W'(SET_PHASE_CYCLES - 1))
            begin
               en_r   <= 1'b0;
               set_r  <= 1'b0;
               done_r <= 1'b1;
            end
         end
      end
   end

   assign txenpmaphasealign_o = en_r;
   assign txpmasetphase_o     = set_r;
   assign sync_done_o         = done_r;

endmodule

`default_nettype wire

/* verilog/oob_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module oob_ctrl
(
   input  logic                     tile0_txusrclk20_i,
   input  logic                     tile0_resetdone0_i,
   input  logic                     phyreset_i,
   input  logic                     sync_done_i,
   input  logic                     start_comm_i,
   input  sata_phy_pkg::rxstatus_t  rxstatus_i,
   input  logic                     rxelecidle_i,
   input  logic                     rxbyteisaligned_i,
   input  sata_phy_pkg::prim_code_t rx_prim_i,
   output logic                     txcomstart_o,
   output logic                     txcomtype_o,
   output logic                     txelecidle_o,
   output logic                     link_up_o,
   output logic                     comm_init_o,
   output sata_phy_pkg::tx_mode_t   tx_mode_o
);
   import sata_phy_pkg::*;

   oob_state_t             state_r;
   logic [OOB_TIMER_W-1:0] timer_r;
   logic                   comm_init_r;
   logic                   cominit_det;
   logic                   comwake_det;
   logic                   align_det;
   logic                   nonalign_det;

   assign cominit_det  = (rxstatus_i == RXSTATUS_COMINIT);
   assign comwake_det  = (rxstatus_i == RXSTATUS_COMWAKE);
   // ALIGN counts only from a receiver out of idle and byte-aligned
   assign align_det    = rxbyteisaligned_i && !rxelecidle_i && (rx_prim_i == PRIM_ALIGN);
   assign nonalign_det = (rx_prim_i != PRIM_ALIGN) && (rx_prim_i != PRIM_NONE);

   always_ff @(posedge tile0_txusrclk20_i or negedge tile0_resetdone0_i)
   begin
      if (!tile0_resetdone0_i)
      begin
         state_r     <= OOB_IDLE;
         timer_r     <= '0;
         comm_init_r <= 1'b0;
      end
      else if (phyreset_i)
      begin
         state_r     <= OOB_IDLE;
         timer_r     <= '0;
         comm_init_r <= 1'b0;
      end
      else
      begin
         comm_init_r <= 1'b0;
         timer_r     <= timer_r + 1'b1;
         case (state_r)
            OOB_IDLE:
            begin
               if (sync_done_i && start_comm_i)
               begin
                  state_r <= OOB_COMRESET;
               end
            end
            OOB_COMRESET:
            begin
               state_r <= OOB_WAIT_COMINIT;
               timer_r <= '0;
            end
            OOB_WAIT_COMINIT:
            begin
               if (cominit_det)
               begin
                  comm_init_r <= 1'b1;
                  state_r     <= OOB_COMWAKE;
               end
               else if (timer_r == OOB_TIMER_W'(COMINIT_TIMEOUT - 1))
               begin
                  state_r <= OOB_COMRESET;
               end
            end
            OOB_COMWAKE:
            begin
               state_r <= OOB_WAIT_COMWAKE;
            end
            OOB_WAIT_COMWAKE:
            begin
               if (comwake_det)
               begin
                  state_r <= OOB_WAIT_ALIGN;
                  timer_r <= '0;
               end
            end
            OOB_WAIT_ALIGN:
            begin
               if (align_det)
               begin
                  state_r <= OOB_SEND_ALIGN;
                  timer_r <= '0;
               end
               else if (timer_r == OOB_TIMER_W'(ALIGN_TIMEOUT - 1))
               begin
                  state_r <= OOB_COMRESET;
               end
            end
            OOB_SEND_ALIGN:
            begin
               // Timer counts consecutive non-ALIGN primitives here
               if (!nonalign_det)
               begin
                  timer_r <= '0;
               end
               else if (timer_r == OOB_TIMER_W'(NONALIGN_NEEDED - 1))
               begin
                  state_r <= OOB_LINK_UP;
               end
            end
            OOB_LINK_UP:
            begin
               if (cominit_det)
               begin
                  comm_init_r <= 1'b1;
                  state_r     <= OOB_COMRESET;
               end
            end
            default:
            begin
               state_r <= OOB_IDLE;
            end
         endcase
      end
   end

   always_comb
   begin
      case (state_r)
         OOB_WAIT_ALIGN: tx_mode_o = MODE_D10_2;
         OOB_SEND_ALIGN: tx_mode_o = MODE_ALIGN;
         OOB_LINK_UP:    tx_mode_o = MODE_DATA;
         default:        tx_mode_o = MODE_IDLE;
      endcase
   end

   assign txcomstart_o = (state_r == OOB_COMRESET) || (state_r == OOB_COMWAKE);
   assign txcomtype_o  = (state_r == OOB_COMWAKE);
   assign txelecidle_o = (tx_mode_o == MODE_IDLE);
   assign link_up_o    = (state_r == OOB_LINK_UP);
   assign comm_init_o  = comm_init_r;

endmodule

`default_nettype wire

/* verilog/tx_credit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_credit_fifo
(
   input  logic                 tile0_txusrclk20_i,
   input  logic                 tile0_resetdone0_i,
   input  logic                 phyreset_i,
   input  sata_phy_pkg::dword_t ll_data_i,
   input  sata_phy_pkg::kflag_t ll_kflags_i,
   input  logic                 ll_valid_i,
   input  logic                 link_up_i,
   output logic                 ll_credit_o,
   tx_word_if.fifo_mp           word_if
);
   import sata_phy_pkg::*;

   dword_t              data_mem [FIFO_DEPTH];
   kflag_t              kflag_mem [FIFO_DEPTH];
   logic [CREDIT_W-1:0] wptr_r;
   logic [CREDIT_W-1:0] rptr_r;
   logic [CREDIT_W-1:0] pend_r;
   logic                granted_r;
   logic                credit_r;
   logic                full;
   logic                wr_en;

   assign full  = (wptr_r[CREDIT_W-1] != rptr_r[CREDIT_W-1])
                  && (wptr_r[CREDIT_W-2:0] == rptr_r[CREDIT_W-2:0]);
   assign wr_en = ll_valid_i && link_up_i && !full;

   always_ff @(posedge tile0_txusrclk20_i)
   begin
      if (wr_en)
      begin
         data_mem[wptr_r[CREDIT_W-2:0]]  <= ll_data_i;
         kflag_mem[wptr_r[CREDIT_W-2:0]] <= ll_kflags_i;
      end
   end

   always_ff @(posedge tile0_txusrclk20_i or negedge tile0_resetdone0_i)
   begin
      if (!tile0_resetdone0_i)
      begin
         wptr_r    <= '0;
         rptr_r    <= '0;
         pend_r    <= '0;
         granted_r <= 1'b0;
         credit_r  <= 1'b0;
      end
      else if (phyreset_i || !link_up_i)
      begin
         // Link down flushes the entries and revokes the grant
         wptr_r    <= '0;
         rptr_r    <= '0;
         pend_r    <= '0;
         granted_r <= 1'b0;
         credit_r  <= 1'b0;
      end
      else
      begin
         if (wr_en)
         begin
            wptr_r <= wptr_r + 1'b1;
         end
         if (word_if.pop)
         begin
            rptr_r <= rptr_r + 1'b1;
         end
         // One credit per cycle, a pop with nothing pending goes straight out
         credit_r <= (pend_r != '0) || word_if.pop;
         if (!granted_r)
         begin
            granted_r <= 1'b1;
            pend_r    <= CREDIT_W'(FIFO_DEPTH);
         end
         else if (pend_r != '0)
         begin
            pend_r <= pend_r - 1'b1 + CREDIT_W'(word_if.pop);
         end
      end
   end

   assign word_if.valid  = (wptr_r != rptr_r);
   assign word_if.data   = data_mem[rptr_r[CREDIT_W-2:0]];
   assign word_if.kflags = kflag_mem[rptr_r[CREDIT_W-2:0]];
   assign ll_credit_o    = credit_r;

endmodule

`default_nettype wire

/* verilog/tx_word_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_word_mux
(
   input  logic                   tile0_txusrclk20_i,
   input  logic                   tile0_resetdone0_i,
   input  logic                   phyreset_i,
   input  sata_phy_pkg::tx_mode_t tx_mode_i,
   tx_word_if.mux_mp              word_if,
   output sata_phy_pkg::dword_t   txdata_o,
   output sata_phy_pkg::kflag_t   txcharisk_o
);
   import sata_phy_pkg::*;

   logic [ALIGN_CNT_W-1:0] slot_r;
   logic                   is_data;
   logic                   in_pair;
   dword_t                 data_nxt;
   kflag_t                 kflags_nxt;

   assign is_data = (tx_mode_i == MODE_DATA);
   // Slots past the interval carry the ALIGN pair
   assign in_pair = (slot_r >= ALIGN_CNT_W'(ALIGN_INTERVAL));
   assign word_if.pop = is_data && !in_pair && word_if.valid;

   always_comb
   begin
      data_nxt   = D10_2_DWORD;
      kflags_nxt = '0;
      case (tx_mode_i)
         MODE_ALIGN:
         begin
            data_nxt   = ALIGN_DWORD;
            kflags_nxt = ALIGN_K;
         end
         MODE_DATA:
         begin
            if (in_pair)
            begin
               data_nxt   = ALIGN_DWORD;
               kflags_nxt = ALIGN_K;
            end
            else if (word_if.valid)
            begin
               data_nxt   = word_if.data;
               kflags_nxt = word_if.kflags;
            end
            else
            begin
               data_nxt   = SYNC_DWORD;
               kflags_nxt = SYNC_K;
            end
         end
         default:
         begin
            data_nxt   = D10_2_DWORD;
            kflags_nxt = '0;
         end
      endcase
   end

   always_ff @(posedge tile0_txusrclk20_i)
   begin
      txdata_o    <= data_nxt;
      txcharisk_o <= kflags_nxt;
   end

   always_ff @(posedge tile0_txusrclk20_i or negedge tile0_resetdone0_i)
   begin
      if (!tile0_resetdone0_i)
      begin
         slot_r <= '0;
      end
      else if (phyreset_i || !is_data)
      begin
         slot_r <= '0;
      end
      else if (slot_r == ALIGN_CNT_W'(ALIGN_INTERVAL + 1))
      begin
         slot_r <= '0;
      end
      else
      begin
         slot_r <= slot_r + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* verilog/sata_phy_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sata_phy_top
(
   input  logic                    tile0_txusrclk20_i,
   input  logic                    tile0_resetdone0_i,
   input  logic                    phyreset_i,
   input  logic                    start_comm_i,
   input  sata_phy_pkg::dword_t    rxdata_i,
   input  sata_phy_pkg::kflag_t    rxcharisk_i,
   input  sata_phy_pkg::rxstatus_t rxstatus_i,
   input  logic                    rxelecidle_i,
   input  logic                    rxbyteisaligned_i,
   input  sata_phy_pkg::dword_t    ll_data_i,
   input  sata_phy_pkg::kflag_t    ll_kflags_i,
   input  logic                    ll_valid_i,
   output logic                    ll_credit_o,
   output sata_phy_pkg::dword_t    txdata_o,
   output sata_phy_pkg::kflag_t    txcharisk_o,
   output logic                    txcomstart_o,
   output logic                    txcomtype_o,
   output logic                    txelecidle_o,
   output logic                    txenpmaphasealign_o,
   output logic                    txpmasetphase_o,
   output logic                    link_up_o,
   output logic                    comm_init_o,
   output logic [127:0]            dbg_o
);
   import sata_phy_pkg::*;

   logic       sync_done;
   tx_mode_t   tx_mode;
   prim_code_t rx_code;
   prim_code_t tx_code;

   tx_word_if word_if ();

   tx_phase_sync u_tx_phase_sync (
      .tile0_txusrclk20_i  (tile0_txusrclk20_i),
      .tile0_resetdone0_i  (tile0_resetdone0_i),
      .txenpmaphasealign_o (txenpmaphasealign_o),
      .txpmasetphase_o     (txpmasetphase_o),
      .sync_done_o         (sync_done)
   );

   prim_decoder rx_prim_i (
      .data_i   (rxdata_i),
      .kflags_i (rxcharisk_i),
      .code_o   (rx_code)
   );

   oob_ctrl u_oob_ctrl (
      .tile0_txusrclk20_i (tile0_txusrclk20_i),
      .tile0_resetdone0_i (tile0_resetdone0_i),
      .phyreset_i         (phyreset_i),
      .sync_done_i        (sync_done),
      .start_comm_i       (start_comm_i),
      .rxstatus_i         (rxstatus_i),
      .rxelecidle_i       (rxelecidle_i),
      .rxbyteisaligned_i  (rxbyteisaligned_i),
      .rx_prim_i          (rx_code),
      .txcomstart_o       (txcomstart_o),
      .txcomtype_o        (txcomtype_o),
      .txelecidle_o       (txelecidle_o),
      .link_up_o          (link_up_o),
      .comm_init_o        (comm_init_o),
      .tx_mode_o          (tx_mode)
   );

   tx_credit_fifo u_tx_credit_fifo (
      .tile0_txusrclk20_i (tile0_txusrclk20_i),
      .tile0_resetdone0_i (tile0_resetdone0_i),
      .phyreset_i         (phyreset_i),
      .ll_data_i          (ll_data_i),
      .ll_kflags_i        (ll_kflags_i),
      .ll_valid_i         (ll_valid_i),
      .link_up_i          (link_up_o),
      .ll_credit_o        (ll_credit_o),
      .word_if            (word_if.fifo_mp)
   );

   tx_word_mux u_tx_word_mux (
      .tile0_txusrclk20_i (tile0_txusrclk20_i),
      .tile0_resetdone0_i (tile0_resetdone0_i),
      .phyreset_i         (phyreset_i),
      .tx_mode_i          (tx_mode),
      .word_if            (word_if.mux_mp),
      .txdata_o           (txdata_o),
      .txcharisk_o        (txcharisk_o)
   );

   prim_decoder tx_prim_i (
      .data_i   (txdata_o),
      .kflags_i (txcharisk_o),
      .code_o   (tx_code)
   );

   // Debug word, TX side first
   assign dbg_o[31:0]   = txdata_o;
   assign dbg_o[63:32]  = rxdata_i;
   assign dbg_o[67:64]  = txcharisk_o;
   assign dbg_o[71:68]  = rxcharisk_i;
   assign dbg_o[79:72]  = tx_code;
   assign dbg_o[87:80]  = rx_code;
   assign dbg_o[127:88] = '0;

endmodule

`default_nettype wire

/* verification/tb_sata_phy.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sata_phy;
   import sata_phy_pkg::*;

   localparam int WAIT_LIMIT = 6000;

   logic clk;
   logic rst_n;
   logic phyreset;
   logic start_comm;
   logic [31:0] rxdata;
   logic [3:0] rxcharisk;
   logic [2:0] rxstatus;
   logic rxelecidle;
   logic rxbyteisaligned;
   logic [31:0] ll_data;
   logic [3:0] ll_kflags;
   logic ll_valid;
   logic ll_credit;
   logic [31:0] txdata;
   logic [3:0] txcharisk;
   logic txcomstart;
   logic txcomtype;
   logic txelecidle;
   logic txenpma;
   logic txsetphase;
   logic link_up;
   logic comm_init;
   logic [127:0] dbg;

   int errors = 0;
   int checks = 0;
   int credits = 0;
   int en_only_cnt = 0;
   int set_cnt = 0;
   int comreset_n = 0;
   int comm_init_n = 0;
   int cominit_sent = 0;
   int sync_rx_n = 0;
   int run_non = 0;
   int run_al = 0;
   int pairs = 0;
   int t;
   int first_cr;
   logic phase_done = 0;
   logic prev_set = 0;
   logic prev_link = 0;
   logic prev_cinit = 0;
   logic ll_en = 0;
   logic [31:0] lcg_state = 32'ha8a5e2d8;
   logic [31:0] sb_q[$];
   logic [31:0] exp_word;

   sata_phy_top dut_i (
      .tile0_txusrclk20_i(clk), .tile0_resetdone0_i(rst_n), .phyreset_i(phyreset),
      .start_comm_i(start_comm), .rxdata_i(rxdata), .rxcharisk_i(rxcharisk),
      .rxstatus_i(rxstatus), .rxelecidle_i(rxelecidle), .rxbyteisaligned_i(rxbyteisaligned),
      .ll_data_i(ll_data), .ll_kflags_i(ll_kflags), .ll_valid_i(ll_valid),
      .ll_credit_o(ll_credit), .txdata_o(txdata), .txcharisk_o(txcharisk),
      .txcomstart_o(txcomstart), .txcomtype_o(txcomtype), .txelecidle_o(txelecidle),
      .txenpmaphasealign_o(txenpma), .txpmasetphase_o(txsetphase),
      .link_up_o(link_up), .comm_init_o(comm_init), .dbg_o(dbg)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Primitive table as the link specification lists it
   function automatic logic [7:0] expected_code(logic [31:0] d, logic [3:0] k);
      if (k == 4'b0001 && d == 32'h7B4A_4ABC) return 8'h01;
      if (k == 4'b0001 && d == 32'hB5B5_957C) return 8'h02;
      if (k == 4'b0001 && d == 32'h9999_AA7C) return 8'h04;
      if (k[0]) return 8'hff;
      if (k == 4'b0000 && d == 32'h4A4A_4A4A) return 8'h03;
      return 8'h00;
   endfunction

   task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
      errors++;
      $display("** Error [%s] expected %0h actual %0h at %0t", name, exp, act, $time);
   endtask

   task automatic report_problem(string what);
      errors++;
      $display("** Error: %s at %0t", what, $time);
   endtask

   task automatic timeout_abort(string what);
      errors++;
      $display("Timeout while waiting for %s", what);
      $display("=== FAIL ===");
      $finish;
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // Link-layer model, sends while it holds a credit
   always @(posedge clk)
   begin
      #1;
      if (ll_en && credits > 0)
      begin
         ll_data = next_rand();
         ll_valid = 1'b1;
         credits = credits - 1;
         sb_q.push_back(ll_data);
      end
      else
      begin
         ll_valid = 1'b0;
      end
   end

   // Monitors sample in the middle of the cycle
   always @(negedge clk)
   begin
      checks++;
      if (!link_up) credits = 0;
      else if (ll_credit) credits = credits + 1;
      assert (credits <= FIFO_DEPTH) else report_mismatch("credit_limit", FIFO_DEPTH, credits);
      assert (dbg[79:72] == expected_code(txdata, txcharisk))
         else report_mismatch("dbg_tx_code", expected_code(txdata, txcharisk), dbg[79:72]);
      assert (dbg[87:80] == expected_code(rxdata, rxcharisk))
         else report_mismatch("dbg_rx_code", expected_code(rxdata, rxcharisk), dbg[87:80]);
      assert (dbg[31:0] == txdata) else report_mismatch("dbg_tx_data", txdata, dbg[31:0]);
      assert (dbg[63:32] == rxdata) else report_mismatch("dbg_rx_data", rxdata, dbg[63:32]);
      assert (dbg[71:64] == {rxcharisk, txcharisk})
         else report_mismatch("dbg_kflags", {rxcharisk, txcharisk}, dbg[71:64]);
      assert (dbg[127:88] == '0) else report_mismatch("dbg_upper", 0, dbg[127:88]);
      // Phase-alignment windows
      if (!phase_done)
      begin
         assert (!txcomstart && !ll_credit) else report_problem("OOB or credit before sync");
         assert (txelecidle) else report_problem("electrical idle left before sync");
         if (txenpma && !txsetphase) en_only_cnt++;
         if (txsetphase) set_cnt++;
         if (prev_set && !txsetphase)
         begin
            phase_done = 1'b1;
            assert (en_only_cnt == PHASE_ALIGN_CYCLES)
               else report_mismatch("phase_align_len", PHASE_ALIGN_CYCLES, en_only_cnt);
            assert (set_cnt == SET_PHASE_CYCLES)
               else report_mismatch("set_phase_len", SET_PHASE_CYCLES, set_cnt);
         end
      end
      prev_set = txsetphase;
      if (txcomstart && !txcomtype) comreset_n++;
      if (txcomstart && txcomtype)
         assert (comreset_n > 0) else report_problem("COMWAKE sent before any COMRESET");
      if (comm_init) comm_init_n++;
      assert (!(comm_init && prev_cinit)) else report_problem("comm_init longer than a cycle");
      prev_cinit = comm_init;
      if (!link_up && rxcharisk == SYNC_K && rxdata == SYNC_DWORD) sync_rx_n++;
      if (link_up && !prev_link)
         assert (sync_rx_n >= NONALIGN_NEEDED)
            else report_mismatch("link_up_nonalign", NONALIGN_NEEDED, sync_rx_n);
      // Data-mode dwords, ALIGN pairs and scoreboard
      if (prev_link && link_up)
      begin
         assert (!txelecidle) else report_problem("electrical idle while the link is up");
         if (txdata == ALIGN_DWORD && txcharisk == ALIGN_K)
         begin
            assert (!ll_credit) else report_problem("credit returned during ALIGN pair");
            if (run_non > 0)
            begin
               assert (run_non == ALIGN_INTERVAL)
                  else report_mismatch("align_interval", ALIGN_INTERVAL, run_non);
               run_non = 0;
            end
            run_al++;
         end
         else
         begin
            if (run_al > 0)
            begin
               assert (run_al == 2) else report_mismatch("align_pair_len", 2, run_al);
               pairs++;
               run_al = 0;
            end
            run_non++;
            if (txcharisk == 4'b0000 && txdata != D10_2_DWORD)
            begin
               if (sb_q.size() == 0)
               begin
                  report_problem("data word sent that the link layer never gave");
               end
               else
               begin
                  exp_word = sb_q.pop_front();
                  assert (txdata == exp_word)
                     else report_mismatch("tx_order", exp_word, txdata);
               end
            end
         end
      end
      prev_link = link_up;
   end

   initial
   begin
      clk = 0;
      rst_n = 0;
      phyreset = 0;
      start_comm = 1;
      rxdata = '0;
      rxcharisk = '0;
      rxstatus = '0;
      rxelecidle = 1;
      rxbyteisaligned = 0;
      ll_data = '0;
      ll_kflags = '0;
      ll_valid = 0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1;

      // Device withholds COMINIT, so COMRESET must repeat
      t = 0;
      while (!(txcomstart && !txcomtype) && t < WAIT_LIMIT)
      begin
         next_cycle();
         t++;
      end
      if (!(txcomstart && !txcomtype)) timeout_abort("first COMRESET");
      next_cycle();
      t = 1;
      while (!(txcomstart && !txcomtype) && t < WAIT_LIMIT)
      begin
         next_cycle();
         t++;
      end
      if (!(txcomstart && !txcomtype)) timeout_abort("repeated COMRESET");
      first_cr = t;
      assert (first_cr == COMINIT_TIMEOUT + 1)
         else report_mismatch("comreset_retry", COMINIT_TIMEOUT + 1, first_cr);

      // Answer with COMINIT, then COMWAKE
      repeat (5) next_cycle();
      rxstatus = RXSTATUS_COMINIT;
      cominit_sent++;
      next_cycle();
      rxstatus = '0;
      t = 0;
      while (!(txcomstart && txcomtype) && t < WAIT_LIMIT)
      begin
         next_cycle();
         t++;
      end
      if (!(txcomstart && txcomtype)) timeout_abort("COMWAKE");
      repeat (5) next_cycle();
      rxstatus = RXSTATUS_COMWAKE;
      next_cycle();
      rxstatus = '0;
      t = 0;
      while (txelecidle && t < WAIT_LIMIT)
      begin
         next_cycle();
         t++;
      end
      if (txelecidle) timeout_abort("end of electrical idle");
      repeat (2) next_cycle();
      repeat (10)
      begin
         assert (txdata == D10_2_DWORD) else report_mismatch("d10_2_phase", D10_2_DWORD, txdata);
         next_cycle();
      end

      // ALIGNs from the device, then SYNC
      rxelecidle = 0;
      rxbyteisaligned = 1;
      rxdata = ALIGN_DWORD;
      rxcharisk = ALIGN_K;
      t = 0;
      while (txdata != ALIGN_DWORD && t < WAIT_LIMIT)
      begin
         next_cycle();
         t++;
      end
      if (txdata != ALIGN_DWORD) timeout_abort("ALIGN on txdata");
      assert (!link_up) else report_problem("link up during ALIGN exchange");
      rxdata = SYNC_DWORD;
      sync_rx_n = 0;
      t = 0;
      while (!link_up && t < WAIT_LIMIT)
      begin
         next_cycle();
         t++;
      end
      if (!link_up) timeout_abort("link_up");

      // Initial credits arrive with nothing sent
      repeat (10) next_cycle();
      assert (credits == FIFO_DEPTH) else report_mismatch("initial_credits", FIFO_DEPTH, credits);
      ll_en = 1;
      t = 0;
      while (pairs < 3 && t < 4 * WAIT_LIMIT)
      begin
         next_cycle();
         t++;
      end
      if (pairs < 3) timeout_abort("three ALIGN pairs");
      ll_en = 0;
      t = 0;
      while (sb_q.size() != 0 && t < WAIT_LIMIT)
      begin
         next_cycle();
         t++;
      end
      if (sb_q.size() != 0) timeout_abort("scoreboard to drain");

      // COMINIT after link-up takes the link down
      rxstatus = RXSTATUS_COMINIT;
      cominit_sent++;
      next_cycle();
      rxstatus = '0;
      t = 0;
      while (link_up && t < WAIT_LIMIT)
      begin
         next_cycle();
         t++;
      end
      if (link_up) timeout_abort("link_up to drop");
      repeat (5) next_cycle();
      assert (comm_init_n == cominit_sent)
         else report_mismatch("comm_init_count", cominit_sent, comm_init_n);

      $display("Checks sampled: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("=== PASS ===");
      end
      else
      begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
verilog/sata_phy_pkg.sv
verilog/tx_word_if.sv
verilog/prim_decoder.sv
verilog/tx_phase_sync.sv
verilog/oob_ctrl.sv
verilog/tx_credit_fifo.sv
verilog/tx_word_mux.sv
verilog/sata_phy_top.sv
verification/tb_sata_phy.sv

/* Bender.yml */
package:
  name: sata_phy

sources:
  - files:
      - verilog/sata_phy_pkg.sv
      - verilog/tx_word_if.sv
      - verilog/prim_decoder.sv
      - verilog/tx_phase_sync.sv
      - verilog/oob_ctrl.sv
      - verilog/tx_credit_fifo.sv
      - verilog/tx_word_mux.sv
      - verilog/sata_phy_top.sv
  - target: simulation
    files:
      - verification/tb_sata_phy.sv
